//--- verilog.f
+incdir+verif
verilog/tx_pcs_pkg.sv
verilog/tx_lane_encoder.sv
verilog/tx_lane_scrambler.sv
verilog/tx_scram_stage.sv
verilog/tx_am_inserter.sv
verilog/tx_pcs_40g.sv
verif/tb_tx_pcs_40g.sv

//--- Bender.yml
package:
  name: tx_pcs_40g

sources:
  - files:
      - verilog/tx_pcs_pkg.sv
      - verilog/tx_lane_encoder.sv
      - verilog/tx_lane_scrambler.sv
      - verilog/tx_scram_stage.sv
      - verilog/tx_am_inserter.sv
      - verilog/tx_pcs_40g.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_tx_pcs_40g.sv

//--- verif/tx_pcs_model.svh
// Reference model and stimulus LFSR for the transmit PCS; included inside the testbench module
`ifndef TX_PCS_MODEL_SVH
`define TX_PCS_MODEL_SVH

//////////////////////////////
// Stimulus LFSR
//////////////////////////////

// Galois form, taps 32 22 2 1
localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

function automatic logic lfsr_step(ref logic [31:0] lfsr);
  logic out_bit;
  out_bit = lfsr[0];
  lfsr    = lfsr >> 1;
  if (out_bit) begin
    lfsr = lfsr ^ LFSR_POLY;
  end
  return out_bit;
endfunction

// One LFSR step per bit taken, first bit lands in bit 0
function automatic logic [63:0] lfsr_bits(ref logic [31:0] lfsr, input int unsigned n);
  logic [63:0] val;
  val = '0;
  for (int unsigned i = 0; i < n && i < 64; i++) begin
    val[i] = lfsr_step(lfsr);
  end
  return val;
endfunction

//////////////////////////////
// Encoder and scrambler
//////////////////////////////

function automatic void encode_lane(input  tx_pcs_pkg::block_payload_t txd,
                                    input  tx_pcs_pkg::xgmii_ctrl_t    txc,
                                    output tx_pcs_pkg::block_payload_t payload,
                                    output tx_pcs_pkg::sync_header_t   header);
  int idle_bytes;
  idle_bytes = 0;
  for (int b = 0; b < 8; b++) begin
    idle_bytes += (txd[8*b +: 8] == tx_pcs_pkg::XGMII_IDLE);
  end
  if (txc == 8'h00) begin
    header  = tx_pcs_pkg::SYNC_DATA;
    payload = txd;
  end else begin
    header  = tx_pcs_pkg::SYNC_CTRL;
    payload = {{8{tx_pcs_pkg::CODE_ERROR}}, tx_pcs_pkg::BLOCK_TYPE_CTRL};
    if (txc == 8'hFF && idle_bytes == 8) begin
      payload = {{8{tx_pcs_pkg::CODE_IDLE}}, tx_pcs_pkg::BLOCK_TYPE_CTRL};
    end
  end
endfunction

// Bit-serial scrambler, history kept by the caller across lanes and beats
function automatic tx_pcs_pkg::block_payload_t scramble_lane(
    input tx_pcs_pkg::block_payload_t din, ref tx_pcs_pkg::scram_state_t state);
  tx_pcs_pkg::block_payload_t dout;
  for (int i = 0; i < 64; i++) begin
    dout[i] = din[i] ^ state[38] ^ state[57];
    state   = {state[56:0], dout[i]};
  end
  return dout;
endfunction

`endif

//--- verif/tb_tx_pcs_40g.sv
// Directed testbench for the 40G transmit PCS; compile with verilog.f, top is tb_tx_pcs_40g
`timescale 1ns/10ps
`default_nettype none

module tb_tx_pcs_40g;

  import tx_pcs_pkg::*;

  `include "tx_pcs_model.svh"

  localparam int          CLK_PERIOD   = 8;
  localparam int          RESET_CYCLES = 16;
  localparam int          AM_INTERVAL  = 16;
  localparam logic [31:0] LFSR_SEED    = 32'd78;
  localparam int          DATA_BEATS   = 40;
  localparam int          CTRL_BEATS   = 24;
  localparam int          STREAM_BEATS = 200;
  localparam int          AM_BEATS     = 64;
  localparam int          TOTAL_BEATS  = DATA_BEATS + CTRL_BEATS + STREAM_BEATS + AM_BEATS;
  // Random gaps, marker slots and two resets all fit in the margin
  localparam int          TIMEOUT_NS   = (TOTAL_BEATS * 8 + 2 * RESET_CYCLES) * CLK_PERIOD;

  logic           clk_156;
  logic           async_reset_n;
  block_payload_t txd          [NUM_LANES];
  xgmii_ctrl_t    txc          [NUM_LANES];
  logic           tx_valid;
  logic           tx_ready;
  logic           bypass_scram;
  block_payload_t lane_payload [NUM_LANES];
  sync_header_t   lane_header  [NUM_LANES];
  logic           lane_valid;

  // Beat staged by a test before send_beat
  block_payload_t beat_txd [NUM_LANES];
  xgmii_ctrl_t    beat_txc [NUM_LANES];

  //////////////////////////////
  // Scoreboard state
  //////////////////////////////

  logic [NUM_LANES*64-1:0] exp_pay_q [$];
  logic [NUM_LANES*2-1:0]  exp_hdr_q [$];
  int                      acc_edge_q [$];
  int                      acc_am_q   [$];
  logic [31:0]             lfsr_state;
  scram_state_t            exp_state;
  int                      edge_cnt;
  int                      data_since_am;
  int                      data_total;
  int                      am_total;
  // Beats on the line that carry the marker pattern on every lane
  int                      am_seen;
  logic                    prev_ready;
  int                      error_count;
  int                      check_count;

  tx_pcs_40g #(
    .AM_INTERVAL (AM_INTERVAL)
  ) dut0 (
    .clk_156       (clk_156),
    .async_reset_n (async_reset_n),
    .txd           (txd),
    .txc           (txc),
    .tx_valid      (tx_valid),
    .tx_ready      (tx_ready),
    .bypass_scram  (bypass_scram),
    .lane_payload  (lane_payload),
    .lane_header   (lane_header),
    .lane_valid    (lane_valid)
  );

  initial begin
    clk_156 = 1'b0;
    forever #(CLK_PERIOD / 2) clk_156 = ~clk_156;
  end

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_payload(input string name, input block_payload_t got,
                               input block_payload_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_header(input string name, input sync_header_t got,
                              input sync_header_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  //////////////////////////////
  // Output monitor
  //////////////////////////////

  always @(posedge clk_156) begin
    int acc_edge;
    int acc_am;
    logic [NUM_LANES*64-1:0] exp_pay;
    logic [NUM_LANES*2-1:0]  exp_hdr;
    logic                    marker_match;
    if (!async_reset_n) begin
      data_since_am = 0;
      data_total    = 0;
      am_total      = 0;
      am_seen       = 0;
      prev_ready    = 1'b1;
    end else begin
      if (lane_valid) begin
        marker_match = 1'b1;
        for (int k = 0; k < NUM_LANES; k++) begin
          if (lane_header[k] !== SYNC_CTRL || lane_payload[k] !== AM_PATTERN[k]) begin
            marker_match = 1'b0;
          end
        end
        if (marker_match) begin
          am_seen++;
        end
        if (data_since_am == AM_INTERVAL) begin
          // Marker slot, input paused in the cycle before
          for (int k = 0; k < NUM_LANES; k++) begin
            check_payload($sformatf("marker lane_payload[%0d]", k), lane_payload[k],
                          AM_PATTERN[k]);
            check_header($sformatf("marker lane_header[%0d]", k), lane_header[k], SYNC_CTRL);
          end
          check_flag("tx_ready before marker", prev_ready, 1'b0);
          am_total++;
          data_since_am = 0;
        end else if (exp_pay_q.size() == 0 || acc_edge_q.size() == 0) begin
          error_count++;
          $display("Output beat at edge %0d arrived with no beat accepted for it", edge_cnt);
        end else begin
          exp_pay  = exp_pay_q.pop_front();
          exp_hdr  = exp_hdr_q.pop_front();
          acc_edge = acc_edge_q.pop_front();
          acc_am   = acc_am_q.pop_front();
          for (int k = 0; k < NUM_LANES; k++) begin
            check_payload($sformatf("lane_payload[%0d]", k), lane_payload[k],
                          exp_pay[64*k +: 64]);
            check_header($sformatf("lane_header[%0d]", k), lane_header[k], exp_hdr[2*k +: 2]);
          end
          // Two edges through the pipe, one more per marker slot in between
          check_count++;
          if (edge_cnt != acc_edge + 2 + (am_total - acc_am)) begin
            error_count++;
            $display("Beat accepted at edge %0d came out at edge %0d, wrong latency",
                     acc_edge, edge_cnt);
          end
          data_since_am++;
          data_total++;
        end
      end
      if (tx_valid && tx_ready) begin
        acc_edge_q.push_back(edge_cnt);
        acc_am_q.push_back(am_total);
      end
      prev_ready = tx_ready;
    end
    edge_cnt++;
  end

  //////////////////////////////
  // Drive helpers
  //////////////////////////////

  task automatic apply_reset();
    @(negedge clk_156);
    async_reset_n = 1'b0;
    tx_valid      = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk_156);
    exp_state     = SCRAM_RESET_STATE;
    async_reset_n = 1'b1;
  endtask

  // Holds the beat until tx_ready, then books the expected output
  task automatic send_beat();
    logic [NUM_LANES*64-1:0] exp_pay;
    logic [NUM_LANES*2-1:0]  exp_hdr;
    block_payload_t          pay;
    sync_header_t            hdr;
    @(negedge clk_156);
    for (int k = 0; k < NUM_LANES; k++) begin
      txd[k] = beat_txd[k];
      txc[k] = beat_txc[k];
    end
    tx_valid = 1'b1;
    while (!tx_ready) @(negedge clk_156);
    for (int k = 0; k < NUM_LANES; k++) begin
      encode_lane(beat_txd[k], beat_txc[k], pay, hdr);
      if (!bypass_scram) begin
        pay = scramble_lane(pay, exp_state);
      end
      exp_pay[64*k +: 64] = pay;
      exp_hdr[2*k +: 2]   = hdr;
    end
    exp_pay_q.push_back(exp_pay);
    exp_hdr_q.push_back(exp_hdr);
    @(posedge clk_156);
  endtask

  // Garbage on the data lines must not be taken
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk_156);
      tx_valid = 1'b0;
      for (int k = 0; k < NUM_LANES; k++) begin
        txd[k] = lfsr_bits(lfsr_state, 64);
      end
    end
  endtask

  task automatic drain_pipeline();
    @(negedge clk_156);
    tx_valid = 1'b0;
    while (exp_pay_q.size() != 0) @(negedge clk_156);
    repeat (4) @(negedge clk_156);
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("Test %s finished with %0d errors", name, error_count - errs_before);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic after_reset_idle();
    int errs;
    errs = error_count;
    @(negedge clk_156);
    check_flag("lane_valid", lane_valid, 1'b0);
    check_flag("tx_ready", tx_ready, 1'b1);
    report_test("after_reset_idle", errs);
  endtask

  task automatic bypass_data_beats();
    int errs;
    errs = error_count;
    bypass_scram = 1'b1;
    repeat (DATA_BEATS) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        beat_txd[k] = lfsr_bits(lfsr_state, 64);
        beat_txc[k] = '0;
      end
      send_beat();
    end
    drain_pipeline();
    report_test("bypass_data_beats", errs);
  endtask

  task automatic bypass_control_beats();
    int          errs;
    logic [63:0] kind;
    logic [63:0] pos;
    errs = error_count;
    bypass_scram = 1'b1;
    repeat (CTRL_BEATS) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        kind = lfsr_bits(lfsr_state, 2);
        case (kind[1:0])
          2'd0: begin
            beat_txd[k] = {8{XGMII_IDLE}};
            beat_txc[k] = '1;
          end
          2'd1: begin
            // One start character among idles
            pos         = lfsr_bits(lfsr_state, 3);
            beat_txd[k] = {8{XGMII_IDLE}};
            beat_txd[k][8*pos[2:0] +: 8] = 8'hFB;
            beat_txc[k] = '1;
          end
          2'd2: begin
            beat_txd[k] = lfsr_bits(lfsr_state, 64);
            beat_txc[k] = xgmii_ctrl_t'(lfsr_bits(lfsr_state, 8));
          end
          default: begin
            beat_txd[k] = lfsr_bits(lfsr_state, 64);
            beat_txc[k] = '0;
          end
        endcase
      end
      send_beat();
    end
    drain_pipeline();
    report_test("bypass_control_beats", errs);
  endtask

  task automatic scrambled_random_stream();
    int          errs;
    logic [63:0] gap;
    errs = error_count;
    bypass_scram = 1'b0;
    apply_reset();
    repeat (STREAM_BEATS) begin
      gap = lfsr_bits(lfsr_state, 2);
      idle_cycles(int'(gap[1:0]));
      for (int k = 0; k < NUM_LANES; k++) begin
        beat_txd[k] = lfsr_bits(lfsr_state, 64);
        beat_txc[k] = '0;
      end
      send_beat();
    end
    drain_pipeline();
    report_test("scrambled_random_stream", errs);
  endtask

  task automatic marker_insertion();
    int errs;
    errs = error_count;
    bypass_scram = 1'b0;
    repeat (AM_BEATS) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        beat_txd[k] = lfsr_bits(lfsr_state, 64);
        beat_txc[k] = '0;
      end
      send_beat();
    end
    drain_pipeline();
    check_count++;
    if (am_seen != data_total / AM_INTERVAL) begin
      error_count++;
      $display("Saw %0d marker beats after %0d data beats, expected %0d", am_seen,
               data_total, data_total / AM_INTERVAL);
    end
    report_test("marker_insertion", errs);
  endtask

  //////////////////////////////
  // Sequence and watchdog
  //////////////////////////////

  initial begin
    async_reset_n = 1'b0;
    tx_valid      = 1'b0;
    bypass_scram  = 1'b1;
    for (int k = 0; k < NUM_LANES; k++) begin
      txd[k]      = '0;
      txc[k]      = '0;
      beat_txd[k] = '0;
      beat_txc[k] = '0;
    end
    lfsr_state  = LFSR_SEED;
    exp_state   = SCRAM_RESET_STATE;
    edge_cnt    = 0;
    error_count = 0;
    check_count = 0;
    apply_reset();
    after_reset_idle();
    bypass_data_beats();
    bypass_control_beats();
    scrambled_random_stream();
    marker_insertion();
    $display("Summary: 5 tests, %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns with beats still outstanding", TIMEOUT_NS);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/tx_pcs_40g.sv
// Top level of the 40G transmit PCS; encodes, scrambles and inserts markers on four lanes
`timescale 1ns/10ps
`default_nettype none

module tx_pcs_40g #(
  parameter int AM_INTERVAL = 16
) (
  input  logic                       clk_156,
  input  logic                       async_reset_n,
  input  tx_pcs_pkg::block_payload_t txd          [tx_pcs_pkg::NUM_LANES],
  input  tx_pcs_pkg::xgmii_ctrl_t    txc          [tx_pcs_pkg::NUM_LANES],
  input  logic                       tx_valid,
  output logic                       tx_ready,
  input  logic                       bypass_scram,
  output tx_pcs_pkg::block_payload_t lane_payload [tx_pcs_pkg::NUM_LANES],
  output tx_pcs_pkg::sync_header_t   lane_header  [tx_pcs_pkg::NUM_LANES],
  output logic                       lane_valid
);

  import tx_pcs_pkg::*;

  block_payload_t enc_payload [NUM_LANES];
  sync_header_t   enc_header  [NUM_LANES];
  block_payload_t scr_payload [NUM_LANES];
  sync_header_t   scr_header  [NUM_LANES];
  logic           scr_valid;
  logic           am_stall;
  logic           accept;

  // Input paused for the marker cycle
  assign tx_ready = !am_stall;
  assign accept   = tx_valid && tx_ready;

  //////////////////////////////
  // Lane encoders
  //////////////////////////////

  for (genvar k = 0; k < NUM_LANES; k++) begin : g_enc
    tx_lane_encoder inst_encoder (
      .txd         (txd[k]),
      .txc         (txc[k]),
      .enc_payload (enc_payload[k]),
      .enc_header  (enc_header[k])
    );
  end

  //////////////////////////////
  // Scramble and marker stages
  //////////////////////////////

  tx_scram_stage inst_scram_stage (
    .clk_156       (clk_156),
    .async_reset_n (async_reset_n),
    .enc_payload   (enc_payload),
    .enc_header    (enc_header),
    .accept        (accept),
    .stall         (am_stall),
    .bypass_scram  (bypass_scram),
    .scr_payload   (scr_payload),
    .scr_header    (scr_header),
    .scr_valid     (scr_valid)
  );

  tx_am_inserter #(
    .AM_INTERVAL (AM_INTERVAL)
  ) inst_am_inserter (
    .clk_156       (clk_156),
    .async_reset_n (async_reset_n),
    .scr_payload   (scr_payload),
    .scr_header    (scr_header),
    .scr_valid     (scr_valid),
    .lane_payload  (lane_payload),
    .lane_header   (lane_header),
    .lane_valid    (lane_valid),
    .am_stall      (am_stall)
  );

endmodule

`default_nettype wire

//--- verilog/tx_am_inserter.sv
// Output stage; counts data beats and inserts one alignment marker beat every AM_INTERVAL beats
`timescale 1ns/10ps
`default_nettype none

module tx_am_inserter #(
  parameter int AM_INTERVAL = 16
) (
  input  logic                       clk_156,
  input  logic                       async_reset_n,
  input  tx_pcs_pkg::block_payload_t scr_payload  [tx_pcs_pkg::NUM_LANES],
  input  tx_pcs_pkg::sync_header_t   scr_header   [tx_pcs_pkg::NUM_LANES],
  input  logic                       scr_valid,
  output tx_pcs_pkg::block_payload_t lane_payload [tx_pcs_pkg::NUM_LANES],
  output tx_pcs_pkg::sync_header_t   lane_header  [tx_pcs_pkg::NUM_LANES],
  output logic                       lane_valid,
  output logic                       am_stall
);

  import tx_pcs_pkg::*;

  localparam int CNT_W = (AM_INTERVAL > 1) ? $clog2(AM_INTERVAL) : 1;

  typedef logic [CNT_W-1:0] beat_cnt_t;
  typedef enum logic {AM_COUNT, AM_INSERT} am_state_t;

  localparam beat_cnt_t LAST_BEAT = beat_cnt_t'(AM_INTERVAL - 1);

  am_state_t am_state;
  beat_cnt_t beat_cnt;
  logic      am_beat_out;

  // Marker slot steals the cycle of the pending scrambled beat
  assign am_stall = (am_state == AM_INSERT);

  //////////////////////////////
  // Marker FSM
  //////////////////////////////

  always_ff @(posedge clk_156 or negedge async_reset_n) begin
    if (!async_reset_n) begin
      am_state   <= AM_COUNT;
      beat_cnt   <= '0;
      lane_valid <= 1'b0;
    end else begin
      case (am_state)
        AM_INSERT: begin
          am_state   <= AM_COUNT;
          lane_valid <= 1'b1;
        end
        default: begin
          lane_valid <= scr_valid;
          // Only beats actually sent count toward the interval
          if (scr_valid) begin
            if (beat_cnt == LAST_BEAT) begin
              beat_cnt <= '0;
              am_state <= AM_INSERT;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
      endcase
    end
  end

  // Output beat, marker or data
  always_ff @(posedge clk_156) begin
    for (int k = 0; k < NUM_LANES; k++) begin
      if (am_stall) begin
        lane_payload[k] <= AM_PATTERN[k];
        lane_header[k]  <= SYNC_CTRL;
      end else if (scr_valid) begin
        lane_payload[k] <= scr_payload[k];
        lane_header[k]  <= scr_header[k];
      end
    end
  end

  // Marker seen on the line, lane 0 is enough
  assign am_beat_out = lane_valid && (lane_header[0] == SYNC_CTRL) &&
                       (lane_payload[0] == AM_PATTERN[0]);

  a_no_double_am : assert property (@(posedge clk_156) disable iff (!async_reset_n)
    am_beat_out |=> !am_beat_out);

  a_stall_one_cycle : assert property (@(posedge clk_156) disable iff (!async_reset_n)
    am_stall |=> !am_stall);

endmodule

`default_nettype wire

//--- verilog/tx_scram_stage.sv
// Registered scramble stage; chains the four lane scramblers and holds the state across beats
`timescale 1ns/10ps
`default_nettype none

module tx_scram_stage (
  input  logic                       clk_156,
  input  logic                       async_reset_n,
  input  tx_pcs_pkg::block_payload_t enc_payload [tx_pcs_pkg::NUM_LANES],
  input  tx_pcs_pkg::sync_header_t   enc_header  [tx_pcs_pkg::NUM_LANES],
  input  logic                       accept,
  input  logic                       stall,
  input  logic                       bypass_scram,
  output tx_pcs_pkg::block_payload_t scr_payload [tx_pcs_pkg::NUM_LANES],
  output tx_pcs_pkg::sync_header_t   scr_header  [tx_pcs_pkg::NUM_LANES],
  output logic                       scr_valid
);

  import tx_pcs_pkg::*;

  scram_state_t   scram_state;
  scram_state_t   chain_state [NUM_LANES+1];
  block_payload_t lane_scr    [NUM_LANES];

  //////////////////////////////
  // Scrambler chain
  //////////////////////////////

  // Lane 0 continues from where lane 3 of the last beat stopped
  assign chain_state[0] = scram_state;

  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    tx_lane_scrambler inst_scrambler (
      .payload_in  (enc_payload[k]),
      .state_in    (chain_state[k]),
      .bypass      (bypass_scram),
      .payload_out (lane_scr[k]),
      .state_out   (chain_state[k+1])
    );
  end

  //////////////////////////////
  // Beat registers
  //////////////////////////////

  always_ff @(posedge clk_156 or negedge async_reset_n) begin
    if (!async_reset_n) begin
      scram_state <= SCRAM_RESET_STATE;
      scr_valid   <= 1'b0;
    end else if (!stall) begin
      scr_valid <= accept;
      if (accept) begin
        scram_state <= chain_state[NUM_LANES];
      end
    end
  end

  // Held as is while a marker takes the line
  always_ff @(posedge clk_156) begin
    if (accept && !stall) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        scr_payload[k] <= lane_scr[k];
        scr_header[k]  <= enc_header[k];
      end
    end
  end

  // History frozen across a marker so scrambling resumes seamlessly
  a_state_hold : assert property (@(posedge clk_156) disable iff (!async_reset_n)
    stall |=> $stable(scram_state));

  // Top must not accept while the inserter holds the pipe
  a_no_accept_in_stall : assert property (@(posedge clk_156) disable iff (!async_reset_n)
    stall |-> !accept);

endmodule

`default_nettype wire

//--- verilog/tx_lane_scrambler.sv
// Combinational self-synchronous scrambler for one lane payload, state chained lane to lane
`timescale 1ns/10ps
`default_nettype none

module tx_lane_scrambler (
  input  tx_pcs_pkg::block_payload_t payload_in,
  input  tx_pcs_pkg::scram_state_t   state_in,
  input  logic                       bypass,
  output tx_pcs_pkg::block_payload_t payload_out,
  output tx_pcs_pkg::scram_state_t   state_out
);

  import tx_pcs_pkg::*;

  localparam int STATE_W = $bits(scram_state_t);

  block_payload_t scr_bits;
  scram_state_t   scr_state;

  // Bit 0 is the first bit on the line
  always_comb begin
    scr_state = state_in;
    for (int i = 0; i < $bits(block_payload_t); i++) begin
      scr_bits[i] = payload_in[i] ^ scr_state[SCRAM_TAP_A] ^ scr_state[SCRAM_TAP_B];
      scr_state   = {scr_state[STATE_W-2:0], scr_bits[i]};
    end
  end

  // Bypass leaves both the payload and the history untouched
  assign payload_out = bypass ? payload_in : scr_bits;
  assign state_out   = bypass ? state_in : scr_state;

endmodule

`default_nettype wire

//--- verilog/tx_lane_encoder.sv
// Combinational 64b/66b encoder for one XGMII lane; the top instantiates one per lane
`timescale 1ns/10ps
`default_nettype none

module tx_lane_encoder (
  input  tx_pcs_pkg::block_payload_t txd,
  input  tx_pcs_pkg::xgmii_ctrl_t    txc,
  output tx_pcs_pkg::block_payload_t enc_payload,
  output tx_pcs_pkg::sync_header_t   enc_header
);

  import tx_pcs_pkg::*;

  logic all_idle;

  // Every byte of the lane carries the idle character
  always_comb begin
    all_idle = 1'b1;
    for (int b = 0; b < 8; b++) begin
      if (txd[8*b +: 8] != XGMII_IDLE) begin
        all_idle = 1'b0;
      end
    end
  end

  //////////////////////////////
  // Block selection
  //////////////////////////////

  always_comb begin
    if (txc == '0) begin
      // Pure data, sent as is
      enc_header  = SYNC_DATA;
      enc_payload = txd;
    end else if (txc == '1 && all_idle) begin
      enc_header  = SYNC_CTRL;
      enc_payload = {{8{CODE_IDLE}}, BLOCK_TYPE_CTRL};
    end else begin
      // Start, terminate or mixed lanes all fall back to error codes
      enc_header  = SYNC_CTRL;
      enc_payload = {{8{CODE_ERROR}}, BLOCK_TYPE_CTRL};
    end
  end

  // Only the two legal sync headers leave the encoder
  a_header_legal : assert final (enc_header == SYNC_DATA || enc_header == SYNC_CTRL)
    else $error("tx_lane_encoder: illegal sync header %b", enc_header);

endmodule

`default_nettype wire

//--- verilog/tx_pcs_pkg.sv
// Shared widths, block constants and marker payloads for the 40G transmit PCS and its testbench
`default_nettype none

package tx_pcs_pkg;

  //////////////////////////////
  // Lane geometry and types
  //////////////////////////////

  localparam int NUM_LANES = 4;

  typedef logic [63:0] block_payload_t;
  typedef logic [7:0]  xgmii_ctrl_t;
  typedef logic [1:0]  sync_header_t;
  // Index 0 is the most recently scrambled bit
  typedef logic [57:0] scram_state_t;

  //////////////////////////////
  // 64b/66b block fields
  //////////////////////////////

  localparam sync_header_t SYNC_DATA       = 2'b01;
  localparam sync_header_t SYNC_CTRL       = 2'b10;
  localparam logic [7:0]   XGMII_IDLE      = 8'h07;
  localparam logic [7:0]   BLOCK_TYPE_CTRL = 8'h1E;
  localparam logic [6:0]   CODE_IDLE       = 7'h00;
  localparam logic [6:0]   CODE_ERROR      = 7'h1E;

  // Scrambler polynomial 1 + x^39 + x^58
  localparam scram_state_t SCRAM_RESET_STATE = '1;
  localparam int           SCRAM_TAP_A       = 38;
  localparam int           SCRAM_TAP_B       = 57;

  //////////////////////////////
  // Alignment markers
  //////////////////////////////

  // Marker bytes per lane, byte 0 in bits 7:0
  // BIP fields are fixed at 00 and FF
  localparam block_payload_t AM_PATTERN [NUM_LANES] = '{
    64'hFF_B8_89_6F_00_47_76_90,
    64'hFF_19_3B_0F_00_E6_C4_F0,
    64'hFF_64_9A_3A_00_9B_65_C5,
    64'hFF_C2_86_5D_00_3D_79_A2
  };

endpackage

`default_nettype wire
